// ==== vlog.f ====
src/arithPkg.sv
src/arithIfs.sv
src/seqDivider.sv
src/freqModel.sv
src/intervalCoder.sv
src/bitPacker.sv
src/arithEncoderTop.sv
testbench/encoderBind_sva.sv
testbench/encoderChecker.sv
testbench/tbArithEncoder.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds the encoder testbench with Verilator, runs it and checks the log
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --assert -j 0 --top-module tbArithEncoder -f vlog.f -o simArith
./obj_dir/simArith +verilator+error+limit+1000 | tee sim.log

if grep -qF '*** TEST PASSED ***' sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// ==== testbench/tbArithEncoder.sv ====
// testbench top for the arithmetic encoder, drives random symbol streams and reads the words
module tbArithEncoder;
    timeunit 1ns;
    timeprecision 100ps;
    import arithPkg::*;

    localparam int NumShort = 24;
    localparam int MaxShortLen = 40;
    localparam int LongLen = 8300;             // runs past the halving threshold
    localparam int TotalSymbols = NumShort * (MaxShortLen + 1) + LongLen + 1;
    localparam int WatchdogCycles = TotalSymbols * 200 + 2000;

    logic clk;
    logic rstn;
    logic symValid;
    logic symReady;
    symbol_t symData;
    logic wordValid;
    logic wordReady;
    logic [WordWidth-1:0] wordData;
    logic wordLast;
    logic [1:0] lastValidByte;
    logic idle;

    bit stallMode;                              // random back-pressure on the reader
    logic [31:0] symSeed;
    logic [31:0] rdySeed;
    int resetErrors;
    int checkErrors;
    int outstanding;
    int assertErrors;

    arithEncoderTop u_dut (.*);
    encoderChecker u_checker (.*, .errors(checkErrors));
    bind arithEncoderTop encoderBind_sva u_sva (.*);

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    task automatic expectBit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s expected %b got %b", $time, name, exp, got);
            resetErrors++;
        end
    endtask

    // starts and ends 1 ns after a rising edge
    task automatic sendSymbol(input symbol_t sym);
        symData = sym;
        symValid = 1'b1;
        @(negedge clk);
        while (!symReady) @(negedge clk);
        @(posedge clk);
        #1 symValid = 1'b0;
    endtask

    task automatic sendStream(input int len, input bit skewed);
        symbol_t sym;
        for (int i = 0; i < len; i++) begin
            symSeed = xorshift(symSeed);
            if (skewed && symSeed[2:0] < 6) sym = symSeed[8] ? symbol_t'(3) : symbol_t'(12);
            else sym = symbol_t'(symSeed[7:4]);
            sendSymbol(sym);
        end
        sendSymbol(EofSymbol);
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // word reader, low about a third of the cycles under back-pressure
    initial begin
        wordReady = 1'b1;
        rdySeed = 32'd14995 ^ 32'h9e3779b9;
        forever begin
            @(posedge clk);
            #1;
            if (stallMode) begin
                rdySeed = xorshift(rdySeed);
                wordReady = (rdySeed % 3) != 0;
            end else begin
                wordReady = 1'b1;
            end
        end
    end

    initial begin
        #(WatchdogCycles * 10);
        $display("watchdog expired after %0d cycles with %0d expected words never produced",
                 WatchdogCycles, outstanding);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        rstn = 1'b0;
        symValid = 1'b0;
        symData = '0;
        stallMode = 1'b0;
        symSeed = 32'd14995;
        repeat (10) @(posedge clk);
        #1 rstn = 1'b1;
        @(negedge clk);
        expectBit("idle", idle, 1'b1);
        expectBit("symReady", symReady, 1'b1);
        expectBit("wordValid", wordValid, 1'b0);
        @(posedge clk);
        #1;
        for (int i = 0; i < NumShort; i++) begin
            stallMode = (i >= NumShort / 2);   // second half of the short streams stalls
            symSeed = xorshift(symSeed);
            sendStream(int'(symSeed % (MaxShortLen + 1)), 1'b0);
        end
        sendStream(LongLen, 1'b1);
        @(negedge clk);
        while (!idle || wordValid || outstanding != 0) @(negedge clk);
        assertErrors = u_dut.u_sva.holdFails + u_dut.u_sva.resetFails + u_dut.u_sva.idleFails;
        $display("errors: %0d reset, %0d word, %0d assertion, %0d words never produced",
                 resetErrors, checkErrors, assertErrors, outstanding);
        if (resetErrors + checkErrors + assertErrors + outstanding == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== testbench/encoderChecker.sv ====
// reference model of the encoder, predicts every output word from accepted symbols and compares
module encoderChecker (
    input logic clk,
    input logic rstn,
    input logic symValid,
    input logic symReady,
    input arithPkg::symbol_t symData,
    input logic wordValid,
    input logic wordReady,
    input logic [31:0] wordData,
    input logic wordLast,
    input logic [1:0] lastValidByte,
    output int errors,
    output int outstanding
);
    timeunit 1ns;
    timeprecision 100ps;
    import arithPkg::*;

    localparam int HalfI = int'(Half);
    localparam int QuarterI = int'(Quarter);
    localparam int ThreeQI = int'(ThreeQuarters);

    int freq [NumSymbols];
    int a;
    int b;
    int w;
    int pending;
    bit inStream;
    logic [31:0] curWord;
    int bitPos;
    logic [31:0] expData [$];
    logic expLast [$];
    logic [1:0] expLvb [$];

    task automatic freshModel();
        for (int i = 0; i < NumSymbols; i++) freq[i] = 1;
        inStream = 1'b0;
        curWord = '0;
        bitPos = 0;
    endtask

    task automatic pushBit(input logic value, input logic last);
        curWord[bitPos[4:0]] = value;
        if (bitPos == 31 || last) begin
            expData.push_back(curWord);
            expLast.push_back(last);
            expLvb.push_back(2'(bitPos / 8));      // byte of the top filled bit
            curWord = '0;
            bitPos = 0;
        end else begin
            bitPos++;
        end
    endtask

    // a decided bit releases the pending bits of the opposite value
    task automatic emitDecided(input logic value);
        pushBit(value, 1'b0);
        while (pending > 0) begin
            pushBit(!value, 1'b0);
            pending--;
        end
    endtask

    task automatic adaptModel(input int s);
        int total;
        total = 0;
        for (int i = 0; i < NumSymbols; i++) total += freq[i];
        if (total == int'(MaxTotal)) begin
            for (int i = 0; i < NumSymbols; i++) begin
                if (freq[i] > 1) freq[i] = freq[i] / 2;
            end
        end
        freq[s]++;      // increment lands after any halving
    endtask

    task automatic encodeSymbol(input int s);
        int low;
        int total;
        int upper;
        logic finalBit;
        low = 0;
        total = 0;
        if (!inStream) begin
            a = 0;
            b = int'(Whole);
            w = int'(Whole);
            pending = 0;
            inStream = 1'b1;
        end
        for (int i = 0; i < NumSymbols; i++) begin
            if (i < s) low += freq[i];
            total += freq[i];
        end
        upper = a + w * (low + freq[s]) / total;
        a = a + w * low / total;
        b = upper;
        while (1) begin
            if (b < HalfI) begin
                emitDecided(1'b0);
                a = a * 2;
                b = b * 2;
            end else if (a > HalfI) begin
                emitDecided(1'b1);
                a = (a - HalfI) * 2;
                b = (b - HalfI) * 2;
            end else if (a > QuarterI && b < ThreeQI) begin
                pending++;
                a = (a - QuarterI) * 2;
                b = (b - QuarterI) * 2;
            end else begin
                break;
            end
        end
        if (s == int'(EofSymbol)) begin
            pending++;
            finalBit = (a > QuarterI);
            pushBit(finalBit, 1'b0);
            for (int k = 1; k <= pending; k++) pushBit(!finalBit, k == pending);
            freshModel();                          // next stream starts from scratch
        end else begin
            w = b - a;
            adaptModel(s);
        end
    endtask

    task automatic compareField(input string name, input logic [31:0] expVal,
                                input logic [31:0] gotVal);
        if (gotVal !== expVal) begin
            $display("FAILED at %0t: %s expected %h got %h", $time, name, expVal, gotVal);
            errors++;
        end
    endtask

    task automatic checkWord();
        if (expData.size() == 0) begin
            $display("extra word %h arrived at %0t when no word was expected", wordData, $time);
            errors++;
        end else begin
            compareField("wordData", expData.pop_front(), wordData);
            compareField("wordLast", 32'(expLast.pop_front()), 32'(wordLast));
            compareField("lastValidByte", 32'(expLvb.pop_front()), 32'(lastValidByte));
        end
    endtask

    // handshakes seen at the falling edge, ahead of the rising edge that takes them
    always @(negedge clk) begin
        if (!rstn) begin
            freshModel();
            expData.delete();
            expLast.delete();
            expLvb.delete();
        end else begin
            if (wordValid && wordReady) checkWord();
            if (symValid && symReady) encodeSymbol(int'(symData));
        end
        outstanding = expData.size();
    end

endmodule

// ==== testbench/encoderBind_sva.sv ====
// handshake assertions, bound into the encoder top level by the testbench
module encoderBind_sva (
    input logic clk,
    input logic rstn,
    input logic symReady,
    input logic idle,
    input logic wordValid,
    input logic wordReady,
    input logic [31:0] wordData,
    input logic wordLast,
    input logic [1:0] lastValidByte
);
    timeunit 1ns;
    timeprecision 100ps;

    int holdFails;
    int resetFails;
    int idleFails;

    // an offered word stays put until the reader takes it
    wordHeld: assert property (@(posedge clk) disable iff (!rstn)
        wordValid && !wordReady |=> wordValid && $stable(wordData) && $stable(wordLast)
            && $stable(lastValidByte))
    else begin
        $error("word output changed or dropped before it was accepted");
        holdFails++;
    end

    wordQuietInReset: assert property (@(posedge clk) !rstn |=> !wordValid)
    else begin
        $error("wordValid high during or right after reset");
        resetFails++;
    end

    idleAccepts: assert property (@(posedge clk) disable iff (!rstn) idle |-> symReady)
    else begin
        $error("symReady low while the encoder is idle");
        idleFails++;
    end

endmodule

// ==== src/arithEncoderTop.sv ====
// top level of the arithmetic encoder: symbol stream in, packed word stream out
module arithEncoderTop (
    input  logic clk,
    input  logic rstn,
    input  logic symValid,
    output logic symReady,
    input  arithPkg::symbol_t symData,
    output logic wordValid,
    input  logic wordReady,
    output logic [arithPkg::WordWidth-1:0] wordData,
    output logic wordLast,
    output logic [1:0] lastValidByte,
    output logic idle
);

    divIf divBus ();
    modelIf modelBus ();
    bitIf bitBus ();

    seqDivider u_divider (
        .clk  (clk),
        .rstn (rstn),
        .div  (divBus)
    );

    freqModel u_model (
        .clk   (clk),
        .rstn  (rstn),
        .model (modelBus)
    );

    // bit producer
    intervalCoder u_coder (
        .clk      (clk),
        .rstn     (rstn),
        .symValid (symValid),
        .symReady (symReady),
        .symData  (symData),
        .idle     (idle),
        .div      (divBus),
        .model    (modelBus),
        .bits     (bitBus)
    );

    bitPacker u_packer (
        .clk           (clk),
        .rstn          (rstn),
        .bits          (bitBus),
        .wordValid     (wordValid),
        .wordReady     (wordReady),
        .wordData      (wordData),
        .wordLast      (wordLast),
        .lastValidByte (lastValidByte)
    );

endmodule

// ==== src/bitPacker.sv ====
// packs coder bits LSB first into 32-bit words and holds each word until it is read
module bitPacker (
    input  logic clk,
    input  logic rstn,
    bitIf.sink bits,
    output logic wordValid,
    input  logic wordReady,
    output logic [arithPkg::WordWidth-1:0] wordData,
    output logic wordLast,
    output logic [1:0] lastValidByte
);
    import arithPkg::*;

    logic [$clog2(WordWidth)-1:0] pos;     // next bit position

    // no bits taken while a word is on offer
    assign bits.ready = !wordValid;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wordValid <= 1'b0;
            wordData <= '0;
            wordLast <= 1'b0;
            lastValidByte <= '0;
            pos <= '0;
        end else if (wordValid) begin
            if (wordReady) begin
                wordValid <= 1'b0;
                wordData <= '0;    // keeps the unfilled upper bits at zero
                pos <= '0;
            end
        end else if (bits.valid) begin
            wordData[pos] <= bits.bitData;
            pos <= pos + 1'b1;
            // offer on a full word or at the end of a stream
            if (&pos || bits.last) begin
                wordValid <= 1'b1;
                wordLast <= bits.last;
                lastValidByte <= pos[$bits(pos)-1 -: 2];   // byte of highest filled bit
            end
        end
    end

endmodule

// ==== src/intervalCoder.sv ====
// interval coder FSM: subinterval, scaling, pending bits and stream termination
module intervalCoder (
    input  logic clk,
    input  logic rstn,
    input  logic symValid,
    output logic symReady,
    input  arithPkg::symbol_t symData,
    output logic idle,
    divIf.coder div,
    modelIf.coder model,
    bitIf.source bits
);
    import arithPkg::*;

    typedef enum logic [2:0] {
        Idle,
        NextSym,
        Mul,
        DivHigh,
        DivLow,
        Scale,
        EofBit,
        Pending
    } state_t;

    state_t state;
    symbol_t sym;
    interval_t a;
    interval_t b;
    interval_t w;
    interval_t pending;    // middle scalings not yet resolved
    logic pendBit;
    logic tail;            // pending bits after the end-of-stream bit
    prod_t prodLow;

    logic isEof;
    logic leftCase;
    logic rightCase;
    logic midCase;
    logic settled;

    always_comb begin
        isEof = (sym == EofSymbol);
        leftCase = b < Half;
        rightCase = !leftCase && (a > Half);
        midCase = !leftCase && !rightCase && (a > Quarter) && (b < ThreeQuarters);
        settled = !(leftCase || rightCase || midCase);
    end

    assign idle = (state == Idle);
    assign symReady = idle || (state == NextSym && model.ready);

    assign model.symbol = sym;
    assign model.update = (state == Scale) && settled && !isEof;
    assign model.clear = bits.valid && bits.ready && bits.last;

    // high bound goes first, the low product is kept for the second division
    assign div.start = (state == Mul) || (state == DivHigh && div.done);
    assign div.dividend = (state == Mul) ? prod_t'(w) * prod_t'(model.highBound) : prodLow;
    assign div.divisor = model.total;

    assign bits.valid = (state == Scale && (leftCase || rightCase)) ||
                        (state == EofBit) || (state == Pending);
    assign bits.last = (state == Pending) && (pending == 1) && tail;

    always_comb begin
        case (state)
            Scale: bits.bitData = rightCase;
            EofBit: bits.bitData = (a > Quarter);
            default: bits.bitData = pendBit;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= Idle;
            pending <= '0;
            tail <= 1'b0;
        end else begin
            case (state)
                Idle: begin
                    if (symValid) begin
                        sym <= symData;
                        a <= '0;
                        b <= Whole;
                        w <= Whole;
                        pending <= '0;
                        state <= Mul;
                    end
                end
                NextSym: begin
                    if (symValid && model.ready) begin
                        sym <= symData;
                        state <= Mul;
                    end
                end
                Mul: begin
                    prodLow <= prod_t'(w) * prod_t'(model.lowBound);
                    state <= DivHigh;
                end
                DivHigh: begin
                    if (div.done) begin
                        b <= a + div.quotient[Precision-1:0];    // uses the old a
                        state <= DivLow;
                    end
                end
                DivLow: begin
                    if (div.done) begin
                        a <= a + div.quotient[Precision-1:0];
                        state <= Scale;
                    end
                end
                Scale: begin
                    if (leftCase || rightCase) begin
                        if (bits.ready) begin
                            a <= rightCase ? (a - Half) << 1 : a << 1;
                            b <= rightCase ? (b - Half) << 1 : b << 1;
                            pendBit <= leftCase;        // opposite of the emitted bit
                            if (pending != 0) state <= Pending;
                        end
                    end else if (midCase) begin
                        a <= (a - Quarter) << 1;
                        b <= (b - Quarter) << 1;
                        pending <= pending + 1'b1;
                    end else if (isEof) begin
                        pending <= pending + 1'b1;
                        state <= EofBit;
                    end else begin
                        w <= b - a;                     // model update pulses here
                        state <= NextSym;
                    end
                end
                EofBit: begin
                    if (bits.ready) begin
                        pendBit <= (a <= Quarter);
                        tail <= 1'b1;
                        state <= Pending;
                    end
                end
                Pending: begin
                    if (bits.ready) begin
                        pending <= pending - 1'b1;
                        if (pending == 1) begin
                            state <= tail ? Idle : Scale;
                            tail <= 1'b0;
                        end
                    end
                end
                default: state <= Idle;
            endcase
        end
    end

endmodule

// ==== src/freqModel.sv ====
// adaptive frequency model giving cumulative bounds per symbol, with update and halving
module freqModel (
    input logic clk,
    input logic rstn,
    modelIf.model model
);
    import arithPkg::*;

    typedef enum logic [1:0] {
        Idle,
        Halve,
        Walk,
        Apply
    } state_t;

    state_t state;
    freq_t freq [NumSymbols];
    freq_t lowB [NumSymbols];
    freq_t highB [NumSymbols];
    freq_t total;
    symbol_t pendSym;      // symbol whose increment waits for the halving
    symbol_t walkIdx;

    symbol_t incSym;
    logic doInc;

    // lookups for the coder
    assign model.lowBound = lowB[model.symbol];
    assign model.highBound = highB[model.symbol];
    assign model.total = total;
    assign model.ready = (state == Idle);

    assign incSym = (state == Apply) ? pendSym : model.symbol;
    assign doInc = (state == Apply) ||
                   (state == Idle && model.update && total != MaxTotal);

    always_ff @(posedge clk) begin
        if (!rstn || model.clear) begin
            state <= Idle;
            for (int i = 0; i < NumSymbols; i++) begin
                freq[i] <= freq_t'(1);
                lowB[i] <= freq_t'(i);
                highB[i] <= freq_t'(i + 1);
            end
            total <= freq_t'(NumSymbols);
        end else begin
            if (doInc) begin
                freq[incSym] <= freq[incSym] + 1'b1;
                total <= total + 1'b1;
                // bounds of this symbol and all above it move up by one
                for (int i = 0; i < NumSymbols; i++) begin
                    if (i >= int'(incSym)) highB[i] <= highB[i] + 1'b1;
                    if (i > int'(incSym)) lowB[i] <= lowB[i] + 1'b1;
                end
            end

            case (state)
                Idle: begin
                    if (model.update && total == MaxTotal) begin
                        pendSym <= model.symbol;
                        state <= Halve;
                    end
                end
                Halve: begin
                    // a count of one stays, so no symbol loses its interval
                    for (int i = 0; i < NumSymbols; i++) begin
                        if (freq[i] > freq_t'(1)) freq[i] <= freq[i] >> 1;
                    end
                    walkIdx <= '0;
                    total <= '0;       // rebuilt as a running sum during the walk
                    state <= Walk;
                end
                Walk: begin
                    lowB[walkIdx] <= total;
                    highB[walkIdx] <= total + freq[walkIdx];
                    total <= total + freq[walkIdx];
                    walkIdx <= walkIdx + 1'b1;
                    if (walkIdx == symbol_t'(NumSymbols - 1)) state <= Apply;
                end
                Apply: state <= Idle;      // increment applied through doInc
                default: state <= Idle;
            endcase
        end
    end

endmodule

// ==== src/seqDivider.sv ====
// restoring divider used by the interval coder, one quotient bit per clock
module seqDivider (
    input logic clk,
    input logic rstn,
    divIf.divider div
);
    import arithPkg::*;

    typedef logic [$clog2(ProdWidth)-1:0] count_t;

    logic busy;
    count_t count;
    logic [FreqWidth-1:0] rem;
    freq_t divisorReg;
    prod_t quot;

    logic [FreqWidth-1:0] srcRem;
    prod_t srcQuot;
    freq_t srcDivisor;
    logic [FreqWidth:0] trial;
    logic [FreqWidth:0] diff;
    logic fits;

    // the first step runs in the start cycle, straight from the inputs
    always_comb begin
        srcRem = div.start ? '0 : rem;
        srcQuot = div.start ? div.dividend : quot;
        srcDivisor = div.start ? div.divisor : divisorReg;
        trial = {srcRem, srcQuot[ProdWidth-1]};      // shift in next dividend bit
        diff = trial - {1'b0, srcDivisor};
        fits = trial >= {1'b0, srcDivisor};
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            busy <= 1'b0;
            count <= '0;
            div.done <= 1'b0;
        end else begin
            div.done <= 1'b0;
            if (div.start) begin
                busy <= 1'b1;
                count <= count_t'(ProdWidth - 1);
            end else if (busy) begin
                count <= count - 1'b1;
                if (count == 1) begin
                    busy <= 1'b0;
                    div.done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (div.start || busy) begin
            rem <= fits ? diff[FreqWidth-1:0] : trial[FreqWidth-1:0];
            quot <= {srcQuot[ProdWidth-2:0], fits};
        end
        if (div.start) divisorReg <= div.divisor;
    end

    assign div.quotient = quot;

endmodule

// ==== src/arithIfs.sv ====
// interfaces joining the interval coder to the divider, the frequency model and the bit packer
interface divIf;
    import arithPkg::*;

    logic start;           // one-cycle pulse, only while the divider is free
    prod_t dividend;
    freq_t divisor;
    logic done;            // pulses when quotient is valid
    prod_t quotient;

    modport coder (output start, dividend, divisor, input done, quotient);
    modport divider (input start, dividend, divisor, output done, quotient);
endinterface

interface modelIf;
    import arithPkg::*;

    symbol_t symbol;
    logic update;
    logic clear;
    logic ready;           // low while frequencies are being halved
    freq_t lowBound;
    freq_t highBound;
    freq_t total;

    modport coder (output symbol, update, clear, input ready, lowBound, highBound, total);
    modport model (input symbol, update, clear, output ready, lowBound, highBound, total);
endinterface

interface bitIf;
    logic valid;
    logic bitData;
    logic last;            // final bit of a stream
    logic ready;

    modport source (output valid, bitData, last, input ready);
    modport sink (input valid, bitData, last, output ready);
endinterface

// ==== src/arithPkg.sv ====
// shared widths, types and interval constants for the arithmetic encoder, imported by every block
package arithPkg;

    // coder precision and alphabet
    localparam int Precision = 16;
    localparam int NumSymbols = 17;        // sixteen nibble symbols plus end of stream
    localparam int SymWidth = $clog2(NumSymbols);
    localparam int FreqWidth = Precision - 3;
    localparam int ProdWidth = Precision + FreqWidth + 1;  // width times bound, plus headroom
    localparam int WordWidth = 32;

    typedef logic [SymWidth-1:0] symbol_t;
    typedef logic [FreqWidth-1:0] freq_t;
    typedef logic [Precision-1:0] interval_t;
    typedef logic [ProdWidth-1:0] prod_t;

    localparam symbol_t EofSymbol = symbol_t'(16);

    // interval landmarks
    localparam interval_t Whole = interval_t'(1 << (Precision - 1));
    localparam interval_t Half = interval_t'(1 << (Precision - 2));
    localparam interval_t Quarter = interval_t'(1 << (Precision - 3));
    localparam interval_t ThreeQuarters = interval_t'(3 << (Precision - 3));

    // frequencies are halved once the total reaches this
    localparam freq_t MaxTotal = freq_t'(int'(Quarter) - 1);

endpackage
